// File: run.sh
#!/bin/sh
# build and run the lenet pooling testbench with verilator
verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f -o tb_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "All tests passed" sim.log && echo "PASS" && exit 0 \
	|| { echo "FAIL, see sim.log"; exit 1; }

// File: tb.f
verilog/lenet_geom_pkg.sv
verilog/lenet_data_pkg.sv
verilog/layer_en_if.sv
verilog/feature_input.sv
verilog/layer_control.sv
verilog/pool_2x2.sv
verilog/pool_output.sv
verilog/lenet_pool_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: tb/tb_checker.sv
`timescale 1ns/100ps

// scoreboard that models the enable schedule and both pools
// sampled on rising clk so every value is the one from before the edge
module tb_checker
	import lenet_geom_pkg::*;
	import lenet_data_pkg::*;
#(
	parameter int COLS = COLS_DEFAULT
) (
	input  logic     clk,
	input  logic     arst_n,
	input  c1_feat_t c1_data,
	input  c3_feat_t c3_data,
	input  logic     read,
	input  logic     c3_en,
	input  logic     c5_en,
	input  c1_feat_t s2_data,
	input  logic     s2_valid,
	input  logic     s2_frame_done,
	input  c3_feat_t s4_data,
	input  logic     s4_valid,
	input  logic     s4_frame_done,
	input  logic     end_run,
	output int       tests_failed
);

	string test_name [1:6] = '{"reset and read", "s2 schedule", "s2 data",
		"s2 frame done", "s4 data and frame", "c3/c5 enable counts"};
	int err [1:6];
	int n;	// edges since reset release
	logic reported;

	// schedule model state after edge n-2
	int m_t, m_s2cnt, m_c3cnt, m_s4cnt;
	logic m_keep2, m_keep4, m_seen, m_fall, m_fall_d, m_c3b;

	// pool model per stream where 0 is s2 and 1 is s4
	int p_col [2], p_hold [2], res_cnt [2];
	logic p_odd [2];
	int lbuf [2][14];
	int q_val [2][$];
	int q_at [2][$];	// edge on which the strobe is due

	int obs_c3, obs_c5, mod_c3, mod_c5;

	function automatic int relu(input int v);
		return (v < 0) ? 0 : v;
	endfunction

	function automatic int max2(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	task automatic pool_feed(input int s, input int v);
		int len;
		int hm;
		len = (s == 0) ? C1_LEN : C3_LEN;
		if (p_col[s] % 2 == 0) begin
			p_hold[s] = v;
		end else begin
			hm = max2(v, p_hold[s]);
			if (!p_odd[s]) begin
				lbuf[s][p_col[s] / 2] = hm;	// upper row of the window
			end else begin
				q_val[s].push_back(max2(hm, lbuf[s][p_col[s] / 2]));
				q_at[s].push_back(n + 3);	// input reg, pool, output reg
			end
		end
		p_col[s]++;
		if (p_col[s] == len) begin
			p_col[s] = 0;
			p_odd[s] = ~p_odd[s];
		end
	endtask

	task automatic check_stream(input int s, input logic v, input int d, input logic fd);
		int want;
		int due;
		int per;
		int tdat;
		int tfd;
		per  = (s == 0) ? S2_LEN * S2_LEN : S4_LEN * S4_LEN;
		tdat = (s == 0) ? 3 : 5;
		tfd  = (s == 0) ? 4 : 5;
		if (v) begin
			if (q_val[s].size() == 0) begin
				$display("stream %0d strobed at %0t with no pooled window due", s, $time);
				err[s == 0 ? 2 : 5]++;
			end else begin
				want = q_val[s].pop_front();
				due  = q_at[s].pop_front();
				if (due != n) begin
					$display("stream %0d strobe at edge %0d, expected at edge %0d", s, n, due);
					err[s == 0 ? 2 : 5]++;
				end
				if (d != want) begin
					$display("FAILED %0t: stream %0d data %0d, expected %0d", $time, s, d, want);
					err[tdat]++;
				end
				if (fd != (res_cnt[s] % per == per - 1)) begin
					$display("FAILED %0t: stream %0d frame_done %0b at result %0d",
						$time, s, fd, res_cnt[s]);
					err[tfd]++;
				end
				res_cnt[s]++;
			end
		end else begin
			if (q_at[s].size() != 0 && q_at[s][0] <= n) begin
				$display("stream %0d result due at edge %0d was never strobed", s, q_at[s][0]);
				err[s == 0 ? 2 : 5]++;
				void'(q_val[s].pop_front());
				void'(q_at[s].pop_front());
			end
			if (fd) begin
				$display("stream %0d frame_done pulsed without a result at %0t", s, $time);
				err[tfd]++;
			end
		end
	endtask

	// one step of the schedule rules that returns the enables for this state
	task automatic sched_step(output logic c3n, output logic c5n);
		logic s2n;
		logic s4n;
		logic s2b;
		logic s4b;
		logic c5b;
		s2b = (m_t >= 4 * COLS + 4);
		s4b = (m_t >= S4_START - 1);
		c5b = (m_t >= C5_START - 1);
		s2n = ((C1_LEN + m_t) % COLS) < C1_LEN;
		c3n = m_c3b && s2n && (m_s2cnt < C1_LEN - 1) && m_keep2 && (m_s2cnt % 2 == 0);
		s4n = s4b && c3n && (m_c3cnt < C3_LEN);
		c5n = c5b && s4n && m_keep4 && (m_s4cnt % 2 == 0);
		m_c3b    = m_c3b | (m_fall_d & s2n);	// two cycles after the first s2 gap
		m_fall_d = m_fall;
		m_fall   = m_seen & ~s2n;
		m_seen   = m_seen | (s2n & s2b);
		if (s2n) begin
			m_s2cnt = (m_s2cnt == C1_LEN - 1) ? 0 : m_s2cnt + 1;
			if (m_s2cnt == 0)
				m_keep2 = ~m_keep2;
		end
		if (c3n && s4b)
			m_c3cnt = (m_c3cnt == S2_LEN - 1) ? 0 : m_c3cnt + 1;
		if (s4n && c5b) begin
			m_s4cnt = (m_s4cnt == C3_LEN - 1) ? 0 : m_s4cnt + 1;
			if (m_s4cnt == 0)
				m_keep4 = ~m_keep4;
		end
		m_t++;
		if (s2n)
			pool_feed(0, relu(int'(c1_data)));
		if (s4n)
			pool_feed(1, relu(int'(c3_data)));
	endtask

	initial begin
		n            = 0;
		m_t          = 0;
		reported     = 1'b0;
		m_s2cnt      = C1_LEN - 2;
		m_c3cnt      = 0;
		m_s4cnt      = 0;
		m_keep2      = 1'b1;
		m_keep4      = 1'b1;
		m_seen       = 1'b0;
		m_fall       = 1'b0;
		m_fall_d     = 1'b0;
		m_c3b        = 1'b0;
		obs_c3       = 0;
		obs_c5       = 0;
		mod_c3       = 0;
		mod_c5       = 0;
		tests_failed = 0;
		for (int i = 1; i <= 6; i++)
			err[i] = 0;
		for (int s = 0; s < 2; s++) begin
			p_col[s]   = 0;
			p_hold[s]  = 0;
			p_odd[s]   = 1'b0;
			res_cnt[s] = 0;
		end
	end

	always @(posedge clk) begin
		logic c3n;
		logic c5n;
		if (!arst_n) begin
			if (read || c3_en || c5_en || s2_valid || s4_valid) begin
				$display("FAILED %0t: an enable or strobe is high during reset", $time);
				err[1]++;
			end
		end else if (!reported) begin
			n++;
			if (read !== (n == 2)) begin
				$display("FAILED %0t: read %0b at edge %0d", $time, read, n);
				err[1]++;
			end
			if (n <= 2 && (c3_en || c5_en)) begin
				$display("FAILED %0t: c3_en or c5_en came up right after reset", $time);
				err[1]++;
			end
			if (n == 3)
				$display("test 1 %s: %s", test_name[1], err[1] == 0 ? "passed" : "failed");
			check_stream(0, s2_valid, int'(s2_data), s2_frame_done);
			check_stream(1, s4_valid, int'(s4_data), s4_frame_done);
			c3n = 1'b0;
			c5n = 1'b0;
			if (n >= 2)
				sched_step(c3n, c5n);
			obs_c3 += c3_en;
			obs_c5 += c5_en;
			mod_c3 += c3n;
			mod_c5 += c5n;
			if (n % COLS == 0) begin
				if (obs_c3 != mod_c3 || obs_c5 != mod_c5) begin
					$display("FAILED %0t: window c3 %0d/%0d c5 %0d/%0d (seen/expected)",
						$time, obs_c3, mod_c3, obs_c5, mod_c5);
					err[6]++;
				end
				obs_c3 = 0;
				obs_c5 = 0;
				mod_c3 = 0;
				mod_c5 = 0;
			end
			if (end_run) begin
				reported = 1'b1;
				if (res_cnt[0] == 0 || res_cnt[1] == 0) begin
					$display("a pooled stream produced no results at all");
					err[res_cnt[0] == 0 ? 2 : 5]++;
				end
				for (int i = 2; i <= 6; i++)
					$display("test %0d %s: %s", i, test_name[i], err[i] == 0 ? "passed" : "failed");
				for (int i = 1; i <= 6; i++)
					tests_failed += (err[i] != 0);
			end
		end
	end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/100ps

// testbench top for lenet_pool_top
module tb_top
	import lenet_geom_pkg::*;
	import lenet_data_pkg::*;
;

	localparam int PERIOD       = 100;	// ns
	localparam int RESET_CYCLES = 16;
	localparam int RUN_CYCLES   = 3200;	// about three s2 frames
	localparam int DRAIN        = 8;	// lets the last results leave the pipe
	localparam int MARGIN       = 200;
	localparam int SEED         = 91216;

	logic     clk;
	logic     arst_n;
	c1_feat_t c1_data;
	c3_feat_t c3_data;
	logic     read, c3_en, c5_en;
	c1_feat_t s2_data;
	logic     s2_valid, s2_frame_done;
	c3_feat_t s4_data;
	logic     s4_valid, s4_frame_done;
	logic     end_run;	// tells the checker to close its tests
	int       tests_failed;
	logic [31:0] lfsr;

	lenet_pool_top #(.COLS(COLS_DEFAULT)) dut_i (
		.clk(clk), .arst_n(arst_n), .c1_data(c1_data), .c3_data(c3_data),
		.read(read), .c3_en(c3_en), .c5_en(c5_en),
		.s2_data(s2_data), .s2_valid(s2_valid), .s2_frame_done(s2_frame_done),
		.s4_data(s4_data), .s4_valid(s4_valid), .s4_frame_done(s4_frame_done)
	);

	tb_checker #(.COLS(COLS_DEFAULT)) checker_i (
		.clk(clk), .arst_n(arst_n), .c1_data(c1_data), .c3_data(c3_data),
		.read(read), .c3_en(c3_en), .c5_en(c5_en),
		.s2_data(s2_data), .s2_valid(s2_valid), .s2_frame_done(s2_frame_done),
		.s4_data(s4_data), .s4_valid(s4_valid), .s4_frame_done(s4_frame_done),
		.end_run(end_run), .tests_failed(tests_failed)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r    = {r[30:0], lfsr[31]};
		end
		return r;
	endfunction

	initial begin
		logic [31:0] r1;
		logic [31:0] r2;
		arst_n  = 1'b0;
		c1_data = '0;
		c3_data = '0;
		end_run = 1'b0;
		lfsr    = SEED;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		repeat (RUN_CYCLES) begin
			@(posedge clk);
			r1 = rand_bits(8);
			r2 = rand_bits(12);
			c1_data <= r1[7:0];	// both signs, relu gets exercised
			c3_data <= r2[11:0];
		end
		repeat (DRAIN) @(posedge clk);
		end_run <= 1'b1;
		@(posedge clk);
		#1;
		$display("tests run 6, passed %0d, failed %0d", 6 - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// watchdog over reset, run and drain
	initial begin
		#(PERIOD * (RESET_CYCLES + RUN_CYCLES + DRAIN + MARGIN));
		$display("watchdog expired, the run did not reach its end");
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: verilog/feature_input.sv
`timescale 1ns/100ps

// input stage for one conv feature stream
// registers every incoming feature and applies relu on the way
module feature_input
	import lenet_data_pkg::*;
#(
	parameter type T = c1_feat_t	// c1 or c3 payload
) (
	input  logic clk,
	input  logic arst_n,
	input  T     in_data,	// raw conv output, one per clock
	output T     out_data	// rectified, one cycle later
);

	logic neg;	// sign bit of the incoming feature

	// sign of a signed payload sits in the top bit
	assign neg = in_data[$bits(T)-1];

	// relu, negatives become zero
	// no enable here, the pool decides which slots count
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_data <= '0;
		end else if (neg) begin
			out_data <= '0;	// clamp
		end else begin
			out_data <= in_data;	// pass through
		end
	end

endmodule

// File: verilog/layer_control.sv
`timescale 1ns/100ps

// layer sequencer for the pooling pipeline
// free-running row schedule, produces s2/c3/s4/c5 enables and rom read
// enables are computed from current counter state and registered
module layer_control
	import lenet_geom_pkg::*;
#(
	parameter int COLS = COLS_DEFAULT	// slots per row, must exceed C1_LEN
) (
	input logic      clk,
	input logic      arst_n,
	layer_en_if.ctrl en
);

	localparam int COL_W  = $clog2(COLS);
	localparam int S2C_W  = $clog2(C1_LEN);
	localparam int C3C_W  = $clog2(S2_LEN);
	localparam int S4C_W  = $clog2(C3_LEN);
	localparam int S2_DLY = 4 * COLS + 4;	// four rows of kernel fill plus a margin
	localparam int S2D_W  = $clog2(S2_DLY + 1);
	localparam int S4D_W  = $clog2(S4_START);
	localparam int C5D_W  = $clog2(C5_START);

	logic             read_done;	// first cycle after reset has passed
	logic [COL_W-1:0] c1_cnt;	// c1 slot within the row
	logic [S2C_W-1:0] s2_cnt;	// s2 inputs within a c1 row
	logic             s2_dontskip;	// alternate s2 rows
	logic [C3C_W-1:0] c3_cnt;	// c3 outputs within an s2 row
	logic [S4C_W-1:0] s4_cnt;	// s4 inputs within a c3 row
	logic             s4_dontskip;	// alternate s4 rows

	// start down counters and their sticky flags
	logic [S2D_W-1:0] s2_dly;
	logic [S4D_W-1:0] s4_dly;
	logic [C5D_W-1:0] c5_dly;
	logic             s2_begin;
	logic             s4_begin;
	logic             c5_begin;

	// c3 start detect chain
	logic c3_seen;	// s2_en has been high once since s2 began
	logic c3_fall;	// s2_en low after that
	logic c3_fall_d;
	logic c3_begin;

	logic s2_en_nxt;
	logic c3_en_nxt;
	logic s4_en_nxt;
	logic c5_en_nxt;

	always_comb begin
		s2_en_nxt = (c1_cnt < C1_LEN);	// valid c1 columns only
		// even s2 columns on kept rows, last column dropped
		c3_en_nxt = c3_begin & s2_en_nxt & (s2_cnt < C1_LEN - 1)
			& s2_dontskip & ~s2_cnt[0];
		s4_en_nxt = s4_begin & c3_en_nxt & (c3_cnt < C3_LEN);	// valid c3 columns
		c5_en_nxt = c5_begin & s4_en_nxt & s4_dontskip & ~s4_cnt[0];
	end

	// rom read pulse and c1 column counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			read_done <= 1'b0;
			en.read   <= 1'b0;
			c1_cnt    <= COL_W'(C1_LEN);	// row starts in the skipped slots
		end else begin
			read_done <= 1'b1;
			en.read   <= ~read_done;	// high for one cycle only
			if (c1_cnt == COL_W'(COLS - 1))
				c1_cnt <= '0;
			else
				c1_cnt <= c1_cnt + 1'b1;
		end
	end

	// start delays, each flag sets one cycle before its counter runs out
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s2_dly   <= S2D_W'(S2_DLY);
			s4_dly   <= S4D_W'(S4_START - 1);
			c5_dly   <= C5D_W'(C5_START - 1);
			s2_begin <= 1'b0;
			s4_begin <= 1'b0;
			c5_begin <= 1'b0;
		end else begin
			if (s2_dly != '0)
				s2_dly <= s2_dly - 1'b1;
			if (s4_dly != '0)
				s4_dly <= s4_dly - 1'b1;
			if (c5_dly != '0)
				c5_dly <= c5_dly - 1'b1;
			s2_begin <= s2_begin | (s2_dly == S2D_W'(1));
			s4_begin <= s4_begin | (s4_dly == S4D_W'(1));
			c5_begin <= c5_begin | (c5_dly == C5D_W'(1));
		end
	end

	// c3 begins on the first s2 row start after the first s2 gap
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			c3_seen   <= 1'b0;
			c3_fall   <= 1'b0;
			c3_fall_d <= 1'b0;
			c3_begin  <= 1'b0;
		end else begin
			c3_seen   <= c3_seen | (s2_en_nxt & s2_begin);
			c3_fall   <= c3_seen & ~s2_en_nxt;	// falling edge seen
			c3_fall_d <= c3_fall;	// two cycle delay
			c3_begin  <= c3_begin | (c3_fall_d & s2_en_nxt);
		end
	end

	// row position counters with the skip toggles
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s2_cnt      <= S2C_W'(C1_LEN - 2);
			s2_dontskip <= 1'b1;
			c3_cnt      <= '0;
			s4_cnt      <= '0;
			s4_dontskip <= 1'b1;
		end else begin
			if (s2_en_nxt) begin
				if (s2_cnt == S2C_W'(C1_LEN - 1)) begin
					s2_cnt      <= '0;
					s2_dontskip <= ~s2_dontskip;	// next row skipped or kept
				end else begin
					s2_cnt <= s2_cnt + 1'b1;
				end
			end
			if (c3_en_nxt & s4_begin) begin
				if (c3_cnt == C3C_W'(S2_LEN - 1))
					c3_cnt <= '0;	// c3 row incl. 4 invalid outputs
				else
					c3_cnt <= c3_cnt + 1'b1;
			end
			if (s4_en_nxt & c5_begin) begin
				if (s4_cnt == S4C_W'(C3_LEN - 1)) begin
					s4_cnt      <= '0;
					s4_dontskip <= ~s4_dontskip;
				end else begin
					s4_cnt <= s4_cnt + 1'b1;
				end
			end
		end
	end

	// registered enables
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			en.s2_en <= 1'b0;
			en.c3_en <= 1'b0;
			en.s4_en <= 1'b0;
			en.c5_en <= 1'b0;
		end else begin
			en.s2_en <= s2_en_nxt;
			en.c3_en <= c3_en_nxt;
			en.s4_en <= s4_en_nxt;
			en.c5_en <= c5_en_nxt;
		end
	end

endmodule

// File: verilog/layer_en_if.sv
`timescale 1ns/100ps

// layer enables of the pooling subsystem
// all levels, sampled on rising clk, no handshake
interface layer_en_if;

	logic read;	// rom read pulse, one cycle after reset
	logic s2_en;	// s2 latches c1 features
	logic c3_en;	// c3 engine reads s2 results
	logic s4_en;	// s4 latches c3 features
	logic c5_en;	// c5 engine reads s4 results

	// the controller drives every enable
	modport ctrl (
		output read, s2_en, c3_en, s4_en, c5_en
	);

	// top level side, routes enables to pools and ports
	modport sink (
		input read, s2_en, c3_en, s4_en, c5_en
	);

endinterface

// File: verilog/lenet_data_pkg.sv
package lenet_data_pkg;

	// widest feature on any stream, sizes the c3 payload
	localparam int FEAT_W_MAX = 12;

	// c1 conv output, one signed feature per clock
	typedef logic signed [7:0] c1_feat_t;

	// c3 conv output, wider since it sums six s2 maps
	typedef logic signed [FEAT_W_MAX-1:0] c3_feat_t;

endpackage

// File: verilog/lenet_geom_pkg.sv
package lenet_geom_pkg;

	// row geometry of the lenet-5 feature maps
	localparam int C1_LEN = 28;	// valid c1 columns per row
	localparam int S2_LEN = 14;	// s2 row length after 2x2 pooling
	localparam int C3_LEN = 10;	// valid c3 columns per row
	localparam int S4_LEN = 5;	// s4 row length after 2x2 pooling

	// schedule start points, in clock cycles after reset
	localparam int S4_START = 432;	// first cycle s4 may take c3 results
	localparam int C5_START = 500;	// first cycle c5 may take s4 results

	// slots per raster row delivered by the conv engines
	// only the first C1_LEN slots of a row carry c1 features
	localparam int COLS_DEFAULT = 32;

endpackage

// File: verilog/lenet_pool_top.sv
`timescale 1ns/100ps

// pooling and sequencing for the lenet-5 pipeline
// c1 -> relu -> s2 pool, c3 -> relu -> s4 pool
module lenet_pool_top
	import lenet_geom_pkg::*;
	import lenet_data_pkg::*;
#(
	parameter int COLS = COLS_DEFAULT
) (
	input  logic     clk,
	input  logic     arst_n,
	input  c1_feat_t c1_data,	// from the c1 engine, raster order
	input  c3_feat_t c3_data,	// from the c3 engine
	output logic     read,	// rom read pulse
	output logic     c3_en,	// c3 engine read enable
	output logic     c5_en,	// c5 engine read enable
	output c1_feat_t s2_data,
	output logic     s2_valid,
	output logic     s2_frame_done,
	output c3_feat_t s4_data,
	output logic     s4_valid,
	output logic     s4_frame_done
);

	layer_en_if en_if ();

	c1_feat_t c1_q;	// rectified c1 feature
	c3_feat_t c3_q;	// rectified c3 feature
	logic     s2_en_d;	// s2_en aligned to c1_q
	logic     s4_en_d;	// s4_en aligned to c3_q
	c1_feat_t s2_pool;
	logic     s2_pool_valid;
	c3_feat_t s4_pool;
	logic     s4_pool_valid;

	feature_input #(.T(c1_feat_t)) u_c1_in (
		.clk(clk), .arst_n(arst_n), .in_data(c1_data), .out_data(c1_q)
	);
	feature_input #(.T(c3_feat_t)) u_c3_in (
		.clk(clk), .arst_n(arst_n), .in_data(c3_data), .out_data(c3_q)
	);

	layer_control #(.COLS(COLS)) u_ctrl (
		.clk(clk), .arst_n(arst_n), .en(en_if.ctrl)
	);

	// input stage adds a cycle, delay the pool enables to match
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s2_en_d <= 1'b0;
			s4_en_d <= 1'b0;
		end else begin
			s2_en_d <= en_if.s2_en;
			s4_en_d <= en_if.s4_en;
		end
	end

	assign read  = en_if.read;
	assign c3_en = en_if.c3_en;
	assign c5_en = en_if.c5_en;

	pool_2x2 #(.T(c1_feat_t), .LEN(C1_LEN)) u_s2_pool (
		.clk(clk), .arst_n(arst_n), .en(s2_en_d), .in_data(c1_q),
		.out_data(s2_pool), .out_valid(s2_pool_valid)
	);
	pool_2x2 #(.T(c3_feat_t), .LEN(C3_LEN)) u_s4_pool (
		.clk(clk), .arst_n(arst_n), .en(s4_en_d), .in_data(c3_q),
		.out_data(s4_pool), .out_valid(s4_pool_valid)
	);

	pool_output #(.T(c1_feat_t), .OUTS_PER_FRAME(S2_LEN * S2_LEN)) u_s2_out (
		.clk(clk), .arst_n(arst_n), .in_data(s2_pool), .in_valid(s2_pool_valid),
		.data(s2_data), .valid(s2_valid), .frame_done(s2_frame_done)
	);
	pool_output #(.T(c3_feat_t), .OUTS_PER_FRAME(S4_LEN * S4_LEN)) u_s4_out (
		.clk(clk), .arst_n(arst_n), .in_data(s4_pool), .in_valid(s4_pool_valid),
		.data(s4_data), .valid(s4_valid), .frame_done(s4_frame_done)
	);

endmodule

// File: verilog/pool_2x2.sv
`timescale 1ns/100ps

// streaming 2x2 max pool
// even column holds, odd column gives the horizontal max
// even rows park it in the line buffer, odd rows compare and emit
module pool_2x2
	import lenet_data_pkg::*;
#(
	parameter type T   = c1_feat_t,
	parameter int  LEN = 28	// valid columns per input row, even
) (
	input  logic clk,
	input  logic arst_n,
	input  logic en,	// sample in_data this cycle
	input  T     in_data,
	output T     out_data,
	output logic out_valid	// one cycle after the closing sample
);

	localparam int HALF = LEN / 2;
	localparam int CW   = $clog2(LEN);

	logic [CW-1:0] col;	// column within the current row
	logic          row_odd;	// second row of a window pair
	logic [CW-2:0] idx;	// pair index into the line buffer
	logic          pair_end;	// odd column, pair complete
	T              hold;	// even-column sample
	T              hmax;	// horizontal max of the pair
	T              line_buf [HALF];	// upper row maxima

	assign idx      = col[CW-1:1];
	assign pair_end = en & col[0];
	assign hmax     = (in_data > hold) ? in_data : hold;

	// position tracking, advances only on enabled samples
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			col     <= '0;
			row_odd <= 1'b0;
		end else if (en) begin
			if (col == CW'(LEN - 1)) begin
				col     <= '0;
				row_odd <= ~row_odd;	// next row
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// data path
	always_ff @(posedge clk) begin
		if (en & ~col[0])
			hold <= in_data;
		if (pair_end & ~row_odd)
			line_buf[idx] <= hmax;	// top half of the window
		if (pair_end & row_odd)
			out_data <= (hmax > line_buf[idx]) ? hmax : line_buf[idx];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= pair_end & row_odd;	// window closed
	end

endmodule

// File: verilog/pool_output.sv
`timescale 1ns/100ps

// output stage of a pooled stream
// registers the result and marks the last one of each frame
module pool_output
	import lenet_data_pkg::*;
#(
	parameter type T              = c1_feat_t,
	parameter int  OUTS_PER_FRAME = 196	// pooled results per map
) (
	input  logic clk,
	input  logic arst_n,
	input  T     in_data,
	input  logic in_valid,
	output T     data,
	output logic valid,
	output logic frame_done	// with the last result of a frame
);

	localparam int CNT_W = $clog2(OUTS_PER_FRAME);

	logic [CNT_W-1:0] cnt;	// results so far in this frame
	logic             last;

	assign last = (cnt == CNT_W'(OUTS_PER_FRAME - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid      <= 1'b0;
			frame_done <= 1'b0;
			cnt        <= '0;
		end else begin
			valid      <= in_valid;
			frame_done <= in_valid & last;
			if (in_valid)
				cnt <= last ? '0 : cnt + 1'b1;	// restart per frame
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			data <= in_data;	// holds until the next result
	end

endmodule
